/* sim.f */
i2c_pkg.sv
osd_pkg.sv
i2c_line_filter.sv
i2c_target_fsm.sv
osd_reg_file.sv
osd_char_ram.sv
osd_ctrl_top.sv
osd_ctrl_chk.sv
osd_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module osd_ctrl_tb -o osd_sim || exit 1
out=$(./obj_dir/osd_sim)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

/* osd_ctrl_tb.sv */
`timescale 1ns/1ns

module osd_ctrl_tb;

    localparam logic [6:0] dev_addr   = 7'h3C;
    localparam int         filter_len = 3;
    // clocks per bus phase
    localparam int         phase      = 10;

    logic                        clk;
    logic                        rst_n;
    logic                        scl;
    logic                        sda_drv;
    logic                        sda_in;
    logic                        sda_oe;
    osd_pkg::debug_data_t        debug_data;
    osd_pkg::controller_data_t   controller_data;
    logic [9:0]                  osd_rd_addr;
    logic [7:0]                  osd_rd_data;
    logic                        enable_osd;
    logic [7:0]                  highlight_line;
    osd_pkg::hdmi_video_config_t video_config;

    integer     seed = 84530;
    int         checks = 0;
    int         errors = 0;
    logic [7:0] wr_buf  [16];
    logic [7:0] rd_buf  [16];
    logic [7:0] exp_buf [16];

    // wired-AND bus where the target pulls low on sda_oe
    assign sda_in = sda_drv & ~sda_oe;

    osd_ctrl_top #(
        .dev_addr   (dev_addr),
        .filter_len (filter_len)
    ) osd_ctrl_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .scl             (scl),
        .sda_in          (sda_in),
        .sda_oe          (sda_oe),
        .debug_data      (debug_data),
        .controller_data (controller_data),
        .osd_rd_addr     (osd_rd_addr),
        .osd_rd_data     (osd_rd_data),
        .enable_osd      (enable_osd),
        .highlight_line  (highlight_line),
        .video_config    (video_config)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // checking and bookkeeping
    //////////////////////////////
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("test %s finished with %0d errors", name, errors - err0);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $finish;
    endtask

    // active picture per mode as h_active, v_active and vic
    function automatic logic [31:0] expected_config(input int mode);
        case (mode)
            1:       return {12'd1280, 12'd960, 8'd0};
            2:       return {12'd720, 12'd480, 8'd2};
            3:       return {12'd640, 12'd480, 8'd1};
            default: return {12'd1920, 12'd1080, 8'd16};
        endcase
    endfunction

    //////////////////////////////
    // I2C host model
    //////////////////////////////
    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
    endtask

    // target must let go of sda before a new transfer
    task automatic wait_bus_idle();
        int t;
        t = 0;
        while (sda_oe && t < 200) begin
            @(posedge clk);
            t++;
        end
        if (sda_oe) begin
            abort_run("timeout: target keeps sda pulled low between transfers");
        end
    endtask

    // sda set in the low phase and sampled at the end of the high phase
    task automatic clock_bit(input logic b, output logic s);
        sda_drv <= b;
        wait_clks(phase);
        scl <= 1'b1;
        wait_clks(phase);
        s = sda_in;
        scl <= 1'b0;
        wait_clks(phase);
    endtask

    // also serves as repeated start from scl low
    task automatic i2c_start();
        sda_drv <= 1'b1;
        wait_clks(phase);
        scl <= 1'b1;
        wait_clks(phase);
        sda_drv <= 1'b0;
        wait_clks(phase);
        scl <= 1'b0;
        wait_clks(phase);
    endtask

    task automatic i2c_stop();
        sda_drv <= 1'b0;
        wait_clks(phase);
        scl <= 1'b1;
        wait_clks(phase);
        sda_drv <= 1'b1;
        wait_clks(phase);
    endtask

    // ack is 0 when the target acknowledged
    task automatic i2c_write_byte(input logic [7:0] b, output logic ack);
        logic s;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(b[i], s);
        end
        clock_bit(1'b1, ack);
    endtask

    task automatic i2c_read_byte(input logic nack, output logic [7:0] b);
        logic s;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(1'b1, s);
            b[i] = s;
        end
        clock_bit(nack, s);
    endtask

    // pointer then n bytes from wr_buf
    task automatic write_regs(input logic [7:0] ptr, input int n);
        logic ack;
        wait_bus_idle();
        i2c_start();
        i2c_write_byte({dev_addr, 1'b0}, ack);
        check_value("address ack", 32'(ack), 32'd0);
        i2c_write_byte(ptr, ack);
        check_value("pointer ack", 32'(ack), 32'd0);
        for (int i = 0; i < n; i++) begin
            i2c_write_byte(wr_buf[i], ack);
            check_value("data ack", 32'(ack), 32'd0);
        end
        i2c_stop();
    endtask

    // pointer write and repeated start then n bytes into rd_buf with a NACK on the last
    task automatic read_regs(input logic [7:0] ptr, input int n);
        logic ack;
        wait_bus_idle();
        i2c_start();
        i2c_write_byte({dev_addr, 1'b0}, ack);
        check_value("address ack", 32'(ack), 32'd0);
        i2c_write_byte(ptr, ack);
        check_value("pointer ack", 32'(ack), 32'd0);
        i2c_start();
        i2c_write_byte({dev_addr, 1'b1}, ack);
        check_value("read address ack", 32'(ack), 32'd0);
        for (int i = 0; i < n; i++) begin
            i2c_read_byte(i == n - 1, rd_buf[i]);
        end
        i2c_stop();
    endtask

    task automatic compare_reads(input logic [7:0] base, input int n);
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("reg 0x%0h", base + i), 32'(rd_buf[i]), 32'(exp_buf[i]));
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic reset_defaults();
        int err0;
        err0 = errors;
        check_value("enable_osd", 32'(enable_osd), 32'd0);
        check_value("highlight_line", 32'(highlight_line), 32'd255);
        check_value("video_config", 32'(video_config), expected_config(0));
        check_value("sda_oe", 32'(sda_oe), 32'd0);
        read_regs(8'h80, 4);
        exp_buf[0] = 8'd0;
        exp_buf[1] = 8'd0;
        exp_buf[2] = 8'd255;
        exp_buf[3] = 8'd0;
        compare_reads(8'h80, 4);
        report_test("reset_defaults", err0);
    endtask

    task automatic control_regs();
        int         err0;
        logic [7:0] hl;
        logic       ack;
        err0 = errors;
        hl = 8'($random(seed));
        wr_buf[0] = 8'd1;
        wr_buf[1] = hl;
        write_regs(8'h81, 2);
        check_value("enable_osd", 32'(enable_osd), 32'd1);
        check_value("highlight_line", 32'(highlight_line), 32'(hl));
        read_regs(8'h81, 2);
        exp_buf[0] = 8'd1;
        exp_buf[1] = hl;
        compare_reads(8'h81, 2);
        // another device address would clear enable and move the highlight if accepted
        wait_bus_idle();
        i2c_start();
        i2c_write_byte({dev_addr + 7'd1, 1'b0}, ack);
        check_value("wrong address ack", 32'(ack), 32'd1);
        i2c_write_byte(8'h81, ack);
        i2c_write_byte(8'h00, ack);
        i2c_write_byte(~hl, ack);
        i2c_stop();
        check_value("enable_osd", 32'(enable_osd), 32'd1);
        check_value("highlight_line", 32'(highlight_line), 32'(hl));
        report_test("control_regs", err0);
    endtask

    task automatic video_modes();
        int err0;
        err0 = errors;
        for (int m = 0; m < 4; m++) begin
            wr_buf[0] = 8'(m);
            write_regs(8'h83, 1);
            check_value($sformatf("video_config mode %0d", m), 32'(video_config),
                        expected_config(m));
        end
        // unknown mode keeps the vga timing
        wr_buf[0] = 8'h05;
        write_regs(8'h83, 1);
        check_value("video_config mode 5", 32'(video_config), expected_config(3));
        read_regs(8'h83, 1);
        exp_buf[0] = 8'h05;
        compare_reads(8'h83, 1);
        report_test("video_modes", err0);
    endtask

    task automatic char_ram_burst();
        int         err0;
        logic [2:0] off;
        err0 = errors;
        off = 3'($random(seed));
        wr_buf[0] = {5'd0, off};
        write_regs(8'h80, 1);
        for (int i = 0; i < 8; i++) begin
            wr_buf[i] = 8'($random(seed));
        end
        write_regs(8'h10, 8);
        // video port has one clock of read latency after the address
        for (int i = 0; i < 8; i++) begin
            osd_rd_addr <= {off, 7'(16 + i)};
            wait_clks(2);
            check_value($sformatf("osd_rd_data at 0x%0h", {off, 7'(16 + i)}),
                        32'(osd_rd_data), 32'(wr_buf[i]));
        end
        report_test("char_ram_burst", err0);
    endtask

    task automatic status_readback();
        int                   err0;
        logic [63:0]          rnd;
        logic [11:0]          ctrl;
        osd_pkg::debug_data_t dbg;
        err0 = errors;
        rnd = {$random(seed), $random(seed)};
        dbg = rnd[41:0];
        ctrl = 12'($random(seed));
        debug_data <= dbg;
        controller_data <= ctrl;
        wait_clks(1);
        read_regs(8'h85, 2);
        exp_buf[0] = ctrl[11:4];
        exp_buf[1] = {ctrl[3:0], 4'd0};
        compare_reads(8'h85, 2);
        read_regs(8'h90, 6);
        exp_buf[0] = dbg.pll_errors;
        exp_buf[1] = dbg.frame_counter[7:0];
        exp_buf[2] = {6'd0, dbg.frame_counter[9:8]};
        exp_buf[3] = dbg.pll_status;
        exp_buf[4] = dbg.chip_revision;
        exp_buf[5] = dbg.restart_count;
        compare_reads(8'h90, 6);
        read_regs(8'hA0, 1);
        exp_buf[0] = 8'd0;
        compare_reads(8'hA0, 1);
        report_test("status_readback", err0);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        int asrt;
        scl             = 1'b1;
        sda_drv         = 1'b1;
        rst_n           = 1'b0;
        debug_data      = '0;
        controller_data = '0;
        osd_rd_addr     = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        wait_clks(2);

        reset_defaults();
        control_regs();
        video_modes();
        char_ram_burst();
        status_readback();

        asrt = osd_ctrl_top_i.osd_ctrl_chk_i.fails;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt);
        if (errors == 0 && asrt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* osd_ctrl_chk.sv */
`timescale 1ns/1ns

module osd_ctrl_chk (
    input logic                clk,
    input logic                rst_n,
    input logic                sda_oe,
    input osd_pkg::ram_wr_t    ram_wr,
    input logic [2:0]          offset,
    input i2c_pkg::i2c_state_e state
);

    // failures seen so far, the testbench folds them into its count
    int fails = 0;

    //////////////////////////////
    // reset state
    //////////////////////////////
    // bus released, no RAM write and FSM parked while reset is held
    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !sda_oe && !ram_wr.en && state == i2c_pkg::idle)
    else begin
        $error("sda_oe, ram_wr.en or FSM state active during reset");
        fails = fails + 1;
    end

    //////////////////////////////
    // character RAM port
    //////////////////////////////
    // one write per strobe
    ram_en_single: assert property (@(posedge clk) disable iff (!rst_n)
        ram_wr.en |=> !ram_wr.en)
    else begin
        $error("ram_wr.en held for two cycles");
        fails = fails + 1;
    end

    // window bits come from the offset register
    ram_window: assert property (@(posedge clk) disable iff (!rst_n)
        ram_wr.en |-> ram_wr.addr[9:7] == offset)
    else begin
        $error("ram_wr.addr[9:7] differs from offset register");
        fails = fails + 1;
    end

endmodule

bind osd_ctrl_top osd_ctrl_chk osd_ctrl_chk_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .sda_oe (sda_oe),
    .ram_wr (ram_wr),
    .offset (osd_reg_file_i.offset),
    .state  (i2c_target_fsm_i.state)
);

/* osd_ctrl_top.sv */
`timescale 1ns/1ns

module osd_ctrl_top #(
    parameter logic [6:0] dev_addr   = 7'h3C,
    parameter int         filter_len = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        scl,
    input  logic                        sda_in,
    output logic                        sda_oe,
    input  osd_pkg::debug_data_t        debug_data,
    input  osd_pkg::controller_data_t   controller_data,
    input  logic [9:0]                  osd_rd_addr,
    output logic [7:0]                  osd_rd_data,
    output logic                        enable_osd,
    output logic [7:0]                  highlight_line,
    output osd_pkg::hdmi_video_config_t video_config
);

    i2c_pkg::i2c_events_t events;
    osd_pkg::reg_wr_t     reg_wr;
    osd_pkg::ram_wr_t     ram_wr;
    logic [7:0]           rd_addr;
    logic [7:0]           rd_data;

    //////////////////////////////
    // serial front end
    //////////////////////////////
    i2c_line_filter #(
        .filter_len(filter_len)
    ) i2c_line_filter_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .scl    (scl),
        .sda_in (sda_in),
        .events (events)
    );

    i2c_target_fsm #(
        .dev_addr(dev_addr)
    ) i2c_target_fsm_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .events  (events),
        .sda_oe  (sda_oe),
        .reg_wr  (reg_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    //////////////////////////////
    // registers and character store
    //////////////////////////////
    osd_reg_file osd_reg_file_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .reg_wr          (reg_wr),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .ram_wr          (ram_wr),
        .enable_osd      (enable_osd),
        .highlight_line  (highlight_line),
        .video_config    (video_config),
        .debug_data      (debug_data),
        .controller_data (controller_data)
    );

    osd_char_ram osd_char_ram_i (
        .clk     (clk),
        .wr      (ram_wr),
        .rd_addr (osd_rd_addr),
        .rd_data (osd_rd_data)
    );

endmodule

/* osd_char_ram.sv */
`timescale 1ns/1ns

module osd_char_ram (
    input  logic             clk,
    input  osd_pkg::ram_wr_t wr,
    input  logic [9:0]       rd_addr,
    output logic [7:0]       rd_data
);

    // 1k characters, eight windows of 128
    logic [7:0] mem [1024];

    // host port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // video port, one clock latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* osd_reg_file.sv */
`timescale 1ns/1ns

module osd_reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  osd_pkg::reg_wr_t           reg_wr,
    input  logic [7:0]                 rd_addr,
    output logic [7:0]                 rd_data,
    output osd_pkg::ram_wr_t           ram_wr,
    output logic                       enable_osd,
    output logic [7:0]                 highlight_line,
    output osd_pkg::hdmi_video_config_t video_config,
    input  osd_pkg::debug_data_t       debug_data,
    input  osd_pkg::controller_data_t  controller_data
);

    logic [2:0] offset;
    logic [7:0] reconf;
    logic [11:0] ctrl_bits;

    assign ctrl_bits = controller_data;

    //////////////////////////////
    // read side
    //////////////////////////////
    always_ff @(posedge clk) begin
        case (rd_addr)
            osd_pkg::addr_offset_reg: rd_data <= {5'd0, offset};
            osd_pkg::addr_enable:     rd_data <= {7'd0, enable_osd};
            osd_pkg::addr_highlight:  rd_data <= highlight_line;
            osd_pkg::addr_reconf:     rd_data <= reconf;
            // buttons a..right
            osd_pkg::addr_ctrl_hi:    rd_data <= ctrl_bits[11:4];
            // start, triggers, osd key in the top nibble
            osd_pkg::addr_ctrl_lo:    rd_data <= {ctrl_bits[3:0], 4'd0};
            osd_pkg::addr_dbg_base:   rd_data <= debug_data.pll_errors;
            osd_pkg::addr_dbg_base + 8'd1: rd_data <= debug_data.frame_counter[7:0];
            osd_pkg::addr_dbg_base + 8'd2: rd_data <= {6'd0, debug_data.frame_counter[9:8]};
            osd_pkg::addr_dbg_base + 8'd3: rd_data <= debug_data.pll_status;
            osd_pkg::addr_dbg_base + 8'd4: rd_data <= debug_data.chip_revision;
            osd_pkg::addr_dbg_base + 8'd5: rd_data <= debug_data.restart_count;
            default:                  rd_data <= 8'd0;
        endcase
    end

    //////////////////////////////
    // control registers
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            offset         <= 3'd0;
            enable_osd     <= 1'b0;
            highlight_line <= 8'd255;
            reconf         <= 8'd0;
            video_config   <= osd_pkg::mode_config(osd_pkg::mode_1080p);
        end else if (reg_wr.strobe) begin
            case (reg_wr.addr)
                // upper bits of the character RAM address
                osd_pkg::addr_offset_reg: offset <= reg_wr.data[2:0];
                osd_pkg::addr_enable:     enable_osd <= reg_wr.data[0];
                osd_pkg::addr_highlight:  highlight_line <= reg_wr.data;
                osd_pkg::addr_reconf: begin
                    reconf <= reg_wr.data;
                    // only the four known modes retune the output
                    if (reg_wr.data[3:2] == 2'b00) begin
                        video_config <= osd_pkg::mode_config(
                            osd_pkg::video_mode_e'(reg_wr.data[3:0]));
                    end
                end
                default: begin
                end
            endcase
        end
    end

    //////////////////////////////
    // character RAM writes
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_wr <= '0;
        end else begin
            // low half of the map is the RAM window
            ram_wr.en <= reg_wr.strobe & ~reg_wr.addr[7];
            if (reg_wr.strobe && !reg_wr.addr[7]) begin
                ram_wr.addr <= {offset, reg_wr.addr[6:0]};
                ram_wr.data <= reg_wr.data;
            end
        end
    end

endmodule

/* i2c_target_fsm.sv */
`timescale 1ns/1ns

module i2c_target_fsm #(
    parameter logic [i2c_pkg::addr_w-1:0] dev_addr = 7'h3C
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  i2c_pkg::i2c_events_t events,
    output logic                 sda_oe,
    output osd_pkg::reg_wr_t     reg_wr,
    output logic [7:0]           rd_addr,
    input  logic [7:0]           rd_data
);

    i2c_pkg::i2c_state_e state;

    logic [i2c_pkg::byte_w-1:0] shift;
    logic [3:0]                 bit_cnt;
    logic                       rw;
    logic                       first_byte;
    logic                       host_nack;
    logic [7:0]                 ptr;
    logic [i2c_pkg::byte_w-1:0] byte_in;

    // byte as it stands after the current scl rise
    assign byte_in = {shift[i2c_pkg::byte_w-2:0], events.sda};
    assign rd_addr = ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= i2c_pkg::idle;
            shift      <= '0;
            bit_cnt    <= '0;
            rw         <= 1'b0;
            first_byte <= 1'b1;
            host_nack  <= 1'b0;
            ptr        <= '0;
            sda_oe     <= 1'b0;
            reg_wr     <= '0;
        end else begin
            // strobe is a single cycle
            reg_wr.strobe <= 1'b0;

            if (events.start) begin
                // also a repeated start, pointer kept
                state      <= i2c_pkg::dev_addr;
                bit_cnt    <= '0;
                first_byte <= 1'b1;
                sda_oe     <= 1'b0;
            end else if (events.stop) begin
                state   <= i2c_pkg::idle;
                bit_cnt <= '0;
                sda_oe  <= 1'b0;
            end else begin
                case (state)
                    //////////////////////////////
                    // address phase
                    //////////////////////////////
                    i2c_pkg::dev_addr: begin
                        if (events.scl_rise && bit_cnt != 4'd8) begin
                            shift   <= byte_in;
                            bit_cnt <= bit_cnt + 1'b1;
                        end else if (events.scl_fall && bit_cnt == 4'd8) begin
                            bit_cnt <= '0;
                            if (shift[7:1] == dev_addr) begin
                                rw     <= shift[0];
                                sda_oe <= 1'b1;
                                state  <= i2c_pkg::dev_ack;
                            end else begin
                                // not for us, stay off the bus until next start
                                state <= i2c_pkg::idle;
                            end
                        end
                    end
                    i2c_pkg::dev_ack: begin
                        if (events.scl_fall) begin
                            if (rw) begin
                                // first read byte, msb goes out right away
                                shift  <= rd_data;
                                sda_oe <= ~rd_data[7];
                                state  <= i2c_pkg::rd_byte;
                            end else begin
                                sda_oe <= 1'b0;
                                state  <= i2c_pkg::wr_byte;
                            end
                        end
                    end
                    //////////////////////////////
                    // host to target
                    //////////////////////////////
                    i2c_pkg::wr_byte: begin
                        if (events.scl_rise && bit_cnt != 4'd8) begin
                            shift   <= byte_in;
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 4'd7) begin
                                if (first_byte) begin
                                    ptr        <= byte_in;
                                    first_byte <= 1'b0;
                                end else begin
                                    reg_wr.addr   <= ptr;
                                    reg_wr.data   <= byte_in;
                                    reg_wr.strobe <= 1'b1;
                                    ptr           <= ptr + 1'b1;
                                end
                            end
                        end else if (events.scl_fall && bit_cnt == 4'd8) begin
                            bit_cnt <= '0;
                            sda_oe  <= 1'b1;
                            state   <= i2c_pkg::wr_ack;
                        end
                    end
                    i2c_pkg::wr_ack: begin
                        if (events.scl_fall) begin
                            sda_oe <= 1'b0;
                            state  <= i2c_pkg::wr_byte;
                        end
                    end
                    //////////////////////////////
                    // target to host
                    //////////////////////////////
                    i2c_pkg::rd_byte: begin
                        if (events.scl_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end else if (events.scl_fall) begin
                            if (bit_cnt == 4'd8) begin
                                // free sda for the host ack, move to next byte
                                bit_cnt <= '0;
                                sda_oe  <= 1'b0;
                                ptr     <= ptr + 1'b1;
                                state   <= i2c_pkg::rd_ack;
                            end else begin
                                shift  <= {shift[i2c_pkg::byte_w-2:0], 1'b0};
                                sda_oe <= ~shift[i2c_pkg::byte_w-2];
                            end
                        end
                    end
                    i2c_pkg::rd_ack: begin
                        if (events.scl_rise) begin
                            host_nack <= events.sda;
                        end else if (events.scl_fall) begin
                            if (host_nack) begin
                                // host is done, wait for stop or start
                                state <= i2c_pkg::idle;
                            end else begin
                                shift  <= rd_data;
                                sda_oe <= ~rd_data[7];
                                state  <= i2c_pkg::rd_byte;
                            end
                        end
                    end
                    default: begin
                        sda_oe <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

/* i2c_line_filter.sv */
`timescale 1ns/1ns

module i2c_line_filter #(
    parameter int filter_len = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                scl,
    input  logic                sda_in,
    output i2c_pkg::i2c_events_t events
);

    localparam int cnt_w = $clog2(filter_len + 1);

    // line 0 is scl, line 1 is sda
    logic [1:0] raw;
    logic [1:0] sync1;
    logic [1:0] sync2;
    logic [1:0] filt;
    logic [1:0] filt_d;

    assign raw = {sda_in, scl};

    //////////////////////////////
    // per line sync and deglitch
    //////////////////////////////
    for (genvar i = 0; i < 2; i++) begin : g_line
        logic [cnt_w-1:0] cnt;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                // idle bus floats high
                sync1[i]  <= 1'b1;
                sync2[i]  <= 1'b1;
                filt[i]   <= 1'b1;
                filt_d[i] <= 1'b1;
                cnt       <= '0;
            end else begin
                sync1[i]  <= raw[i];
                sync2[i]  <= sync1[i];
                filt_d[i] <= filt[i];
                if (sync2[i] == filt[i]) begin
                    // glitch gone, start counting again
                    cnt <= '0;
                end else if (cnt == cnt_w'(filter_len - 1)) begin
                    filt[i] <= sync2[i];
                    cnt     <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // edges and bus conditions
    //////////////////////////////
    always_comb begin
        events.scl      = filt[0];
        events.sda      = filt[1];
        events.scl_rise = filt[0] & ~filt_d[0];
        events.scl_fall = ~filt[0] & filt_d[0];
        // sda moving while scl held high
        events.start    = filt[0] & filt_d[0] & filt_d[1] & ~filt[1];
        events.stop     = filt[0] & filt_d[0] & ~filt_d[1] & filt[1];
    end

endmodule

/* osd_pkg.sv */
package osd_pkg;

    // low nibble of the reconfiguration byte
    typedef enum logic [3:0] {
        mode_1080p = 4'd0,
        mode_960p  = 4'd1,
        mode_480p  = 4'd2,
        mode_vga   = 4'd3
    } video_mode_e;

    // active picture and CEA vic of the output mode
    typedef struct packed {
        logic [11:0] h_active;
        logic [11:0] v_active;
        logic [7:0]  vic;
    } hdmi_video_config_t;

    // reduced debug record from the video side
    typedef struct packed {
        logic [7:0] pll_errors;
        logic [9:0] frame_counter;
        logic [7:0] pll_status;
        logic [7:0] chip_revision;
        logic [7:0] restart_count;
    } debug_data_t;

    // pad buttons, msb first
    typedef struct packed {
        logic a;
        logic b;
        logic x;
        logic y;
        logic up;
        logic down;
        logic left;
        logic right;
        logic start;
        logic ltrigger;
        logic rtrigger;
        logic trigger_osd;
    } controller_data_t;

    // register write from the I2C target
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
        logic       strobe;
    } reg_wr_t;

    // character RAM write
    typedef struct packed {
        logic [9:0] addr;
        logic [7:0] data;
        logic       en;
    } ram_wr_t;

    // register map
    localparam logic [7:0] addr_offset_reg = 8'h80;
    localparam logic [7:0] addr_enable     = 8'h81;
    localparam logic [7:0] addr_highlight  = 8'h82;
    localparam logic [7:0] addr_reconf     = 8'h83;
    localparam logic [7:0] addr_ctrl_hi    = 8'h85;
    localparam logic [7:0] addr_ctrl_lo    = 8'h86;
    localparam logic [7:0] addr_dbg_base   = 8'h90;

    // mode to timing lookup, unknown modes fall back to 1080p
    function automatic hdmi_video_config_t mode_config(input video_mode_e mode);
        hdmi_video_config_t cfg;
        case (mode)
            mode_960p: cfg = '{h_active: 12'd1280, v_active: 12'd960, vic: 8'd0};
            mode_480p: cfg = '{h_active: 12'd720, v_active: 12'd480, vic: 8'd2};
            mode_vga:  cfg = '{h_active: 12'd640, v_active: 12'd480, vic: 8'd1};
            default:   cfg = '{h_active: 12'd1920, v_active: 12'd1080, vic: 8'd16};
        endcase
        return cfg;
    endfunction

endpackage

/* i2c_pkg.sv */
package i2c_pkg;

    // widths on the serial side
    localparam int byte_w = 8;
    localparam int addr_w = 7;

    // target FSM states
    typedef enum logic [2:0] {
        idle     = 3'd0,
        dev_addr = 3'd1,
        dev_ack  = 3'd2,
        wr_byte  = 3'd3,
        wr_ack   = 3'd4,
        rd_byte  = 3'd5,
        rd_ack   = 3'd6
    } i2c_state_e;

    // filtered bus levels plus single-cycle event pulses
    typedef struct packed {
        logic scl;
        logic sda;
        logic scl_rise;
        logic scl_fall;
        logic start;
        logic stop;
    } i2c_events_t;

endpackage
